// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
LINTFLAGS := --lint-only --timing --assert
TOP       := tbUsbSlaveEndp
RTL_TOP   := usbSlaveEndp
FILELIST  := usbSlaveEndp.f
OBJ_DIR   := obj_dir
PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the pass message shows up in the simulator output.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tbUsbSlaveEndp.sv ====
`include "usbSlaveDefs.svh"

module tbUsbSlaveEndp;

  timeunit 1ns;
  timeprecision 100ps;

  import usbSlavePkg::*;

  localparam int unsigned RAND_SEED = 32'hbc359f1a;
  localparam int ISO_TRANS = 32;
  localparam int NUM_TRANS = 4 + 4 + 2 + ISO_TRANS + 1;
  localparam int CYCLES_PER_TRANS = 10;
  localparam int MARGIN_CYCLES = 1000;
  localparam int WATCHDOG_CYCLES = NUM_TRANS * CYCLES_PER_TRANS + MARGIN_CYCLES;

  logic clk;
  logic rst;
  logic transDone;
  logic [3:0] tokenEndP;
  transType_t transType;
  logic crcError;
  logic bitStuffError;
  logic rxOverflow;
  logic rxTimeOut;
  logic ackRxed;
  logic dataSequence;
  logic busy;
  logic respValid;
  respPid_t respPid;
  logic [4:0] regAddr;
  logic [7:0] regWrData;
  logic regWe;
  logic [7:0] regRdData;

  // Shadow copy of the endpoint registers.
  logic [4:0] ctrlShadow [4];
  logic [7:0] statusShadow [4];
  logic [1:0] typeShadow [4];
  logic [1:0] nakTypeShadow [4];
  int unsigned seedInit;

  usbSlaveEndp i_dut (
    .clk           (clk),
    .rst           (rst),
    .transDone     (transDone),
    .tokenEndP     (tokenEndP),
    .transType     (transType),
    .crcError      (crcError),
    .bitStuffError (bitStuffError),
    .rxOverflow    (rxOverflow),
    .rxTimeOut     (rxTimeOut),
    .ackRxed       (ackRxed),
    .dataSequence  (dataSequence),
    .busy          (busy),
    .respValid     (respValid),
    .respPid       (respPid),
    .regAddr       (regAddr),
    .regWrData     (regWrData),
    .regWe         (regWe),
    .regRdData     (regRdData)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Run timed out after %0d cycles before all tests finished", WATCHDOG_CYCLES);
    stopWithFailure();
  end

  ////////////////////////////////////////
  // Checking and register access.
  ////////////////////////////////////////
  task automatic stopWithFailure();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic checkEq(input string testName, input string what,
                         input logic [7:0] expected, input logic [7:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s %s expected 0x%02h actual 0x%02h",
               testName, what, expected, actual);
      stopWithFailure();
    end
  endtask

  function automatic logic [4:0] regAddrOf(input logic [1:0] ep, input logic [1:0] offset);
    return {1'b0, ep, offset};
  endfunction

  task automatic writeReg(input logic [4:0] addr, input logic [7:0] data);
    @(posedge clk);
    #1;
    regAddr = addr;
    regWrData = data;
    regWe = 1'b1;
    @(posedge clk);
    #1;
    regWe = 1'b0;
    if (!addr[4] && addr[1:0] == `REG_CONTROL) begin
      ctrlShadow[addr[3:2]] = data[4:0];
    end
  endtask

  task automatic readReg(input logic [4:0] addr, output logic [7:0] data);
    @(posedge clk);
    #1;
    regAddr = addr;
    #1;
    data = regRdData;
  endtask

  task automatic checkEndpoint(input string testName, input logic [1:0] ep);
    logic [7:0] rd;
    readReg(regAddrOf(ep, `REG_CONTROL), rd);
    checkEq(testName, $sformatf("ep%0d control", ep), 8'(ctrlShadow[ep]), rd);
    readReg(regAddrOf(ep, `REG_STATUS), rd);
    checkEq(testName, $sformatf("ep%0d status", ep), statusShadow[ep], rd);
    readReg(regAddrOf(ep, `REG_TRANS_TYPE), rd);
    checkEq(testName, $sformatf("ep%0d trans type", ep), 8'(typeShadow[ep]), rd);
    readReg(regAddrOf(ep, `REG_NAK_TRANS_TYPE), rd);
    checkEq(testName, $sformatf("ep%0d nak type", ep), 8'(nakTypeShadow[ep]), rd);
  endtask

  ////////////////////////////////////////
  // Reference model.
  ////////////////////////////////////////
  function automatic respPid_t expectedResp(input logic [4:0] ctrl);
    logic enabled;
    enabled = ctrl[`EP_ENABLE_BIT];
    if (enabled && ctrl[`EP_SEND_STALL_BIT]) begin
      return RESP_STALL;
    end
    if (enabled && ctrl[`EP_READY_BIT]) begin
      return RESP_ACK;
    end
    return RESP_NAK;
  endfunction

  // Flags are {dataSequence, ackRxed, rxTimeOut, rxOverflow, bitStuffError, crcError}.
  function automatic logic [7:0] flagWord(input logic [5:0] flags, input logic stall);
    logic [7:0] w;
    w = 8'h00;
    w[`ST_CRC_ERROR] = flags[0];
    w[`ST_BIT_STUFF_ERROR] = flags[1];
    w[`ST_RX_OVERFLOW] = flags[2];
    w[`ST_RX_TIMEOUT] = flags[3];
    w[`ST_ACK_RXED] = flags[4];
    w[`ST_DATA_SEQ] = flags[5];
    w[`ST_STALL_SENT] = stall;
    return w;
  endfunction

  task automatic updateModel(input logic [1:0] ep, input respPid_t pid,
                             input transType_t tType, input logic [5:0] flags);
    if (pid == RESP_NAK) begin
      statusShadow[ep] = statusShadow[ep] | `NAK_SET_MASK;
      nakTypeShadow[ep] = tType;
    end else begin
      statusShadow[ep] = flagWord(flags, pid == RESP_STALL);
      typeShadow[ep] = tType;
      ctrlShadow[ep][`EP_READY_BIT] = 1'b0;
    end
  endtask

  ////////////////////////////////////////
  // Transactions.
  ////////////////////////////////////////
  // Returns just after the edge that samples transDone.
  task automatic startTrans(input logic [3:0] endP, input transType_t tType,
                            input logic [5:0] flags);
    @(posedge clk);
    #1;
    transDone = 1'b1;
    tokenEndP = endP;
    transType = tType;
    {dataSequence, ackRxed, rxTimeOut, rxOverflow, bitStuffError, crcError} = flags;
    @(posedge clk);
    #1;
    transDone = 1'b0;
  endtask

  task automatic runTrans(input string testName, input logic [3:0] endP,
                          input transType_t tType, input logic [5:0] flags,
                          output respPid_t gotPid);
    logic [1:0] ep;
    respPid_t expPid;
    ep = endP[1:0];
    expPid = expectedResp(ctrlShadow[ep]);
    startTrans(endP, tType, flags);
    while (!respValid) begin
      @(posedge clk);
      #1;
    end
    gotPid = respPid;
    checkEq(testName, "respPid", 8'(expPid), 8'(respPid));
    while (busy) begin
      @(posedge clk);
      #1;
    end
    updateModel(ep, expPid, tType, flags);
  endtask

  ////////////////////////////////////////
  // Tests.
  ////////////////////////////////////////
  task automatic testResetAndAccess();
    logic [7:0] rd;
    logic [7:0] data;
    for (int a = 0; a < 32; a++) begin
      readReg(5'(a), rd);
      checkEq("reset", $sformatf("addr %0d", a), 8'h00, rd);
    end
    for (int ep = 0; ep < 4; ep++) begin
      data = 8'($urandom);
      writeReg(regAddrOf(2'(ep), `REG_CONTROL), data);
      readReg(regAddrOf(2'(ep), `REG_CONTROL), rd);
      checkEq("regAccess", "control readback", {3'b000, data[4:0]}, rd);
    end
    // Status is read only and the upper half is unmapped.
    writeReg(regAddrOf(2'd1, `REG_STATUS), 8'hff);
    writeReg(5'd20, 8'hff);
    for (int a = 16; a < 32; a++) begin
      readReg(5'(a), rd);
      checkEq("regAccess", $sformatf("addr %0d", a), 8'h00, rd);
    end
    for (int ep = 0; ep < 4; ep++) begin
      checkEndpoint("regAccess", 2'(ep));
    end
  endtask

  task automatic testAckPath();
    logic [7:0] ctrl;
    logic [7:0] rd;
    logic [5:0] flags;
    transType_t tType;
    respPid_t gotPid;
    for (int ep = 0; ep < 4; ep++) begin
      ctrl = 8'($urandom);
      ctrl[`EP_ENABLE_BIT] = 1'b1;
      ctrl[`EP_READY_BIT] = 1'b1;
      ctrl[`EP_SEND_STALL_BIT] = 1'b0;
      writeReg(regAddrOf(2'(ep), `REG_CONTROL), ctrl);
      flags = 6'($urandom);
      tType = transType_t'(2'($urandom));
      runTrans("ack", {2'($urandom), 2'(ep)}, tType, flags, gotPid);
      checkEq("ack", "handshake", 8'(RESP_ACK), 8'(gotPid));
      readReg(regAddrOf(2'(ep), `REG_STATUS), rd);
      checkEq("ack", "status", flagWord(flags, 1'b0), rd);
      readReg(regAddrOf(2'(ep), `REG_CONTROL), rd);
      checkEq("ack", "ready bit", 8'h00, 8'(rd[`EP_READY_BIT]));
      checkEndpoint("ack", 2'(ep));
    end
  endtask

  task automatic testNakPath();
    logic [7:0] ctrl;
    logic [7:0] rd;
    logic [7:0] prevStatus;
    logic [4:0] prevCtrl;
    logic [1:0] prevType;
    transType_t tType;
    respPid_t gotPid;
    for (int ep = 0; ep < 4; ep++) begin
      ctrl = 8'($urandom);
      if (ep < 2) begin
        ctrl[`EP_ENABLE_BIT] = 1'b1;
        ctrl[`EP_READY_BIT] = 1'b0;
        ctrl[`EP_SEND_STALL_BIT] = 1'b0;
      end else begin
        // Disabled endpoints NAK even when ready or stalled.
        ctrl[`EP_ENABLE_BIT] = 1'b0;
        ctrl[`EP_READY_BIT] = 1'b1;
        ctrl[`EP_SEND_STALL_BIT] = (ep == 3);
      end
      writeReg(regAddrOf(2'(ep), `REG_CONTROL), ctrl);
      prevStatus = statusShadow[ep];
      prevCtrl = ctrlShadow[ep];
      prevType = typeShadow[ep];
      tType = transType_t'(2'($urandom));
      runTrans("nak", {2'($urandom), 2'(ep)}, tType, 6'($urandom), gotPid);
      checkEq("nak", "handshake", 8'(RESP_NAK), 8'(gotPid));
      readReg(regAddrOf(2'(ep), `REG_STATUS), rd);
      checkEq("nak", "status", prevStatus | `NAK_SET_MASK, rd);
      readReg(regAddrOf(2'(ep), `REG_TRANS_TYPE), rd);
      checkEq("nak", "trans type", 8'(prevType), rd);
      readReg(regAddrOf(2'(ep), `REG_NAK_TRANS_TYPE), rd);
      checkEq("nak", "nak type", 8'(tType), rd);
      readReg(regAddrOf(2'(ep), `REG_CONTROL), rd);
      checkEq("nak", "control", 8'(prevCtrl), rd);
    end
  endtask

  task automatic testStallPath();
    logic [7:0] ctrl;
    logic [7:0] rd;
    respPid_t gotPid;
    for (int ep = 1; ep < 4; ep += 2) begin
      ctrl = 8'($urandom);
      ctrl[`EP_ENABLE_BIT] = 1'b1;
      ctrl[`EP_SEND_STALL_BIT] = 1'b1;
      ctrl[`EP_READY_BIT] = (ep == 1);
      writeReg(regAddrOf(2'(ep), `REG_CONTROL), ctrl);
      runTrans("stall", {2'($urandom), 2'(ep)}, transType_t'(2'($urandom)),
               6'($urandom), gotPid);
      checkEq("stall", "handshake", 8'(RESP_STALL), 8'(gotPid));
      readReg(regAddrOf(2'(ep), `REG_STATUS), rd);
      checkEq("stall", "stall bit", 8'h01, 8'(rd[`ST_STALL_SENT]));
      readReg(regAddrOf(2'(ep), `REG_CONTROL), rd);
      checkEq("stall", "ready bit", 8'h00, 8'(rd[`EP_READY_BIT]));
      checkEndpoint("stall", 2'(ep));
    end
  endtask

  task automatic testIsolation();
    logic [3:0] endP;
    respPid_t gotPid;
    for (int n = 0; n < ISO_TRANS; n++) begin
      endP = 4'($urandom);
      writeReg(regAddrOf(endP[1:0], `REG_CONTROL), 8'($urandom));
      runTrans("isolation", endP, transType_t'(2'($urandom)), 6'($urandom), gotPid);
    end
    for (int ep = 0; ep < 4; ep++) begin
      checkEndpoint("isolation", 2'(ep));
    end
  endtask

  // The host write is timed onto edge 4, where the clear pulse lands.
  task automatic testReadyClearPriority();
    logic [7:0] ctrl;
    logic [7:0] wrData;
    logic [7:0] rd;
    logic [4:0] expCtrl;
    logic [5:0] flags;
    transType_t tType;
    ctrl = 8'h00;
    ctrl[`EP_ENABLE_BIT] = 1'b1;
    ctrl[`EP_READY_BIT] = 1'b1;
    writeReg(regAddrOf(2'd2, `REG_CONTROL), ctrl);
    wrData = 8'he0;
    wrData[`EP_ENABLE_BIT] = 1'b1;
    wrData[`EP_READY_BIT] = 1'b1;
    wrData[`EP_OUTDATA_SEQ_BIT] = 1'b1;
    wrData[`EP_ISO_ENABLE_BIT] = 1'b1;
    flags = 6'($urandom);
    tType = transType_t'(2'($urandom));
    startTrans(4'd2, tType, flags);
    repeat (2) @(posedge clk);
    #1;
    checkEq("readyClear", "respValid", 8'h01, 8'(respValid));
    checkEq("readyClear", "respPid", 8'(RESP_ACK), 8'(respPid));
    @(posedge clk);
    #1;
    regAddr = regAddrOf(2'd2, `REG_CONTROL);
    regWrData = wrData;
    regWe = 1'b1;
    @(posedge clk);
    #1;
    regWe = 1'b0;
    checkEq("readyClear", "busy", 8'h00, 8'(busy));
    ctrlShadow[2] = wrData[4:0];
    updateModel(2'd2, RESP_ACK, tType, flags);
    expCtrl = wrData[4:0];
    expCtrl[`EP_READY_BIT] = 1'b0;
    readReg(regAddrOf(2'd2, `REG_CONTROL), rd);
    checkEq("readyClear", "control", 8'(expCtrl), rd);
    checkEndpoint("readyClear", 2'd2);
  endtask

  initial begin
    seedInit = $urandom(RAND_SEED);
    rst = 1'b1;
    transDone = 1'b0;
    tokenEndP = 4'd0;
    transType = SETUP_TRANS;
    crcError = 1'b0;
    bitStuffError = 1'b0;
    rxOverflow = 1'b0;
    rxTimeOut = 1'b0;
    ackRxed = 1'b0;
    dataSequence = 1'b0;
    regAddr = 5'd0;
    regWrData = 8'h00;
    regWe = 1'b0;
    for (int ep = 0; ep < 4; ep++) begin
      ctrlShadow[ep] = 5'd0;
      statusShadow[ep] = 8'h00;
      typeShadow[ep] = 2'd0;
      nakTypeShadow[ep] = 2'd0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    testResetAndAccess();
    testAckPath();
    testNakPath();
    testStallPath();
    testIsolation();
    testReadyClearPriority();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== include/usbSlaveDefs.svh ====
`ifndef USB_SLAVE_DEFS_SVH
`define USB_SLAVE_DEFS_SVH

////////////////////////////////////////
// Endpoint control register bits.
////////////////////////////////////////
`define EP_ENABLE_BIT       0
`define EP_READY_BIT        1
`define EP_OUTDATA_SEQ_BIT  2
`define EP_SEND_STALL_BIT   3
`define EP_ISO_ENABLE_BIT   4

////////////////////////////////////////
// Endpoint status register bits.
////////////////////////////////////////
`define ST_CRC_ERROR        0
`define ST_BIT_STUFF_ERROR  1
`define ST_RX_OVERFLOW      2
`define ST_RX_TIMEOUT       3
`define ST_NAK_SENT         4
`define ST_STALL_SENT       5
`define ST_ACK_RXED         6
`define ST_DATA_SEQ         7

// A NAK only sets the NAK sent bit.
`define NAK_SET_MASK        8'h10

// Register offsets inside each endpoint's group of four.
`define REG_CONTROL         2'd0
`define REG_STATUS          2'd1
`define REG_TRANS_TYPE      2'd2
`define REG_NAK_TRANS_TYPE  2'd3

`endif

// ==== rtl/endpMux.sv ====
`include "usbSlaveDefs.svh"

module endpMux (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [3:0]              currEndP,
  input  logic                    NAKSent,
  input  logic                    stallSent,
  input  logic                    CRCError,
  input  logic                    bitStuffError,
  input  logic                    RxOverflow,
  input  logic                    RxTimeOut,
  input  logic                    dataSequence,
  input  logic                    ACKRxed,
  input  usbSlavePkg::transType_t transType,
  input  usbSlavePkg::transType_t transTypeNAK,
  input  logic                    endPMuxErrorsWEn,
  input  logic                    clrEPRdy,
  input  logic [4:0]              endP0ControlReg,
  input  logic [4:0]              endP1ControlReg,
  input  logic [4:0]              endP2ControlReg,
  input  logic [4:0]              endP3ControlReg,
  output logic [4:0]              endPControlReg,
  output logic [7:0]              endP0StatusReg,
  output logic [7:0]              endP1StatusReg,
  output logic [7:0]              endP2StatusReg,
  output logic [7:0]              endP3StatusReg,
  output logic [1:0]              endP0TransTypeReg,
  output logic [1:0]              endP1TransTypeReg,
  output logic [1:0]              endP2TransTypeReg,
  output logic [1:0]              endP3TransTypeReg,
  output logic [1:0]              endP0NAKTransTypeReg,
  output logic [1:0]              endP1NAKTransTypeReg,
  output logic [1:0]              endP2NAKTransTypeReg,
  output logic [1:0]              endP3NAKTransTypeReg,
  output logic                    clrEP0Rdy,
  output logic                    clrEP1Rdy,
  output logic                    clrEP2Rdy,
  output logic                    clrEP3Rdy
);

  logic [7:0] statusReg [4];
  logic [1:0] transTypeReg [4];
  logic [1:0] nakTransTypeReg [4];
  logic [3:0] clrRdy;
  logic [7:0] statusWord;
  logic [1:0] epSel;

  // Only the low two token bits address an endpoint.
  assign epSel = currEndP[1:0];

  ////////////////////////////////////////
  // Control lookup and ready clear.
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      endPControlReg <= '0;
      clrRdy <= '0;
    end else begin
      case (epSel)
        2'd0: endPControlReg <= endP0ControlReg;
        2'd1: endPControlReg <= endP1ControlReg;
        2'd2: endPControlReg <= endP2ControlReg;
        default: endPControlReg <= endP3ControlReg;
      endcase
      clrRdy <= clrEPRdy ? (4'b0001 << epSel) : 4'b0000;
    end
  end

  assign clrEP0Rdy = clrRdy[0];
  assign clrEP1Rdy = clrRdy[1];
  assign clrEP2Rdy = clrRdy[2];
  assign clrEP3Rdy = clrRdy[3];

  ////////////////////////////////////////
  // Status update.
  ////////////////////////////////////////
  // Full status word, NAK bit always clear.
  always_comb begin
    statusWord = '0;
    statusWord[`ST_CRC_ERROR] = CRCError;
    statusWord[`ST_BIT_STUFF_ERROR] = bitStuffError;
    statusWord[`ST_RX_OVERFLOW] = RxOverflow;
    statusWord[`ST_RX_TIMEOUT] = RxTimeOut;
    statusWord[`ST_STALL_SENT] = stallSent;
    statusWord[`ST_ACK_RXED] = ACKRxed;
    statusWord[`ST_DATA_SEQ] = dataSequence;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 4; i++) begin
        statusReg[i] <= '0;
        transTypeReg[i] <= '0;
        nakTransTypeReg[i] <= '0;
      end
    end else if (endPMuxErrorsWEn) begin
      if (NAKSent) begin
        statusReg[epSel] <= statusReg[epSel] | `NAK_SET_MASK;
        nakTransTypeReg[epSel] <= transTypeNAK;
      end else begin
        statusReg[epSel] <= statusWord;
        transTypeReg[epSel] <= transType;
      end
    end
  end

  assign endP0StatusReg = statusReg[0];
  assign endP1StatusReg = statusReg[1];
  assign endP2StatusReg = statusReg[2];
  assign endP3StatusReg = statusReg[3];
  assign endP0TransTypeReg = transTypeReg[0];
  assign endP1TransTypeReg = transTypeReg[1];
  assign endP2TransTypeReg = transTypeReg[2];
  assign endP3TransTypeReg = transTypeReg[3];
  assign endP0NAKTransTypeReg = nakTransTypeReg[0];
  assign endP1NAKTransTypeReg = nakTransTypeReg[1];
  assign endP2NAKTransTypeReg = nakTransTypeReg[2];
  assign endP3NAKTransTypeReg = nakTransTypeReg[3];

  // One status write per transaction from the sequencer.
  assert property (@(posedge clk) disable iff (rst)
    endPMuxErrorsWEn |=> !endPMuxErrorsWEn)
    else $error("status write strobe held for two cycles");

endmodule

// ==== rtl/endpRegFile.sv ====
`include "usbSlaveDefs.svh"

module endpRegFile (
  input  logic       clk,
  input  logic       rst,
  input  logic [4:0] regAddr,
  input  logic [7:0] regWrData,
  input  logic       regWe,
  output logic [7:0] regRdData,
  input  logic       clrEP0Rdy,
  input  logic       clrEP1Rdy,
  input  logic       clrEP2Rdy,
  input  logic       clrEP3Rdy,
  input  logic [7:0] endP0StatusReg,
  input  logic [7:0] endP1StatusReg,
  input  logic [7:0] endP2StatusReg,
  input  logic [7:0] endP3StatusReg,
  input  logic [1:0] endP0TransTypeReg,
  input  logic [1:0] endP1TransTypeReg,
  input  logic [1:0] endP2TransTypeReg,
  input  logic [1:0] endP3TransTypeReg,
  input  logic [1:0] endP0NAKTransTypeReg,
  input  logic [1:0] endP1NAKTransTypeReg,
  input  logic [1:0] endP2NAKTransTypeReg,
  input  logic [1:0] endP3NAKTransTypeReg,
  output logic [4:0] endP0ControlReg,
  output logic [4:0] endP1ControlReg,
  output logic [4:0] endP2ControlReg,
  output logic [4:0] endP3ControlReg
);

  logic [4:0] ctrlReg [4];
  logic [4:0] ctrlNext [4];
  logic [3:0] clrRdy;
  logic [7:0] statusIn [4];
  logic [1:0] transTypeIn [4];
  logic [1:0] nakTransTypeIn [4];
  logic [1:0] rdEp;

  assign clrRdy = {clrEP3Rdy, clrEP2Rdy, clrEP1Rdy, clrEP0Rdy};

  assign statusIn[0] = endP0StatusReg;
  assign statusIn[1] = endP1StatusReg;
  assign statusIn[2] = endP2StatusReg;
  assign statusIn[3] = endP3StatusReg;
  assign transTypeIn[0] = endP0TransTypeReg;
  assign transTypeIn[1] = endP1TransTypeReg;
  assign transTypeIn[2] = endP2TransTypeReg;
  assign transTypeIn[3] = endP3TransTypeReg;
  assign nakTransTypeIn[0] = endP0NAKTransTypeReg;
  assign nakTransTypeIn[1] = endP1NAKTransTypeReg;
  assign nakTransTypeIn[2] = endP2NAKTransTypeReg;
  assign nakTransTypeIn[3] = endP3NAKTransTypeReg;

  ////////////////////////////////////////
  // Control registers.
  ////////////////////////////////////////
  // The ready clear overrides a host write in the same cycle.
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      ctrlNext[i] = ctrlReg[i];
      if (regWe && !regAddr[4] && regAddr[3:2] == 2'(i) && regAddr[1:0] == `REG_CONTROL) begin
        ctrlNext[i] = regWrData[4:0];
      end
      if (clrRdy[i]) begin
        ctrlNext[i][`EP_READY_BIT] = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      ctrlReg[i] <= rst ? 5'd0 : ctrlNext[i];
    end
  end

  assign endP0ControlReg = ctrlReg[0];
  assign endP1ControlReg = ctrlReg[1];
  assign endP2ControlReg = ctrlReg[2];
  assign endP3ControlReg = ctrlReg[3];

  ////////////////////////////////////////
  // Host read decode.
  ////////////////////////////////////////
  assign rdEp = regAddr[3:2];

  always_comb begin
    regRdData = 8'h00;
    if (!regAddr[4]) begin
      case (regAddr[1:0])
        `REG_CONTROL: regRdData = {3'b000, ctrlReg[rdEp]};
        `REG_STATUS: regRdData = statusIn[rdEp];
        `REG_TRANS_TYPE: regRdData = {6'b000000, transTypeIn[rdEp]};
        `REG_NAK_TRANS_TYPE: regRdData = {6'b000000, nakTransTypeIn[rdEp]};
        default: regRdData = 8'h00;
      endcase
    end
  end

endmodule

// ==== rtl/slaveTransCtrl.sv ====
`include "usbSlaveDefs.svh"

module slaveTransCtrl (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    transDone,
  input  logic [3:0]              tokenEndP,
  input  usbSlavePkg::transType_t transType,
  input  logic                    crcError,
  input  logic                    bitStuffError,
  input  logic                    rxOverflow,
  input  logic                    rxTimeOut,
  input  logic                    ackRxed,
  input  logic                    dataSequence,
  input  logic [4:0]              endPControlReg,
  output logic                    busy,
  output logic                    respValid,
  output usbSlavePkg::respPid_t   respPid,
  output logic [3:0]              currEndP,
  output logic                    NAKSent,
  output logic                    stallSent,
  output logic                    endPMuxErrorsWEn,
  output logic                    clrEPRdy,
  output usbSlavePkg::transType_t capTransType,
  output logic                    capCrcError,
  output logic                    capBitStuffError,
  output logic                    capRxOverflow,
  output logic                    capRxTimeOut,
  output logic                    capAckRxed,
  output logic                    capDataSequence
);

  import usbSlavePkg::*;

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    DECIDE,
    RELEASE
  } ctrlState_t;

  ctrlState_t state;
  respPid_t decision;
  logic accept;

  assign accept = (state == IDLE) && transDone;

  ////////////////////////////////////////
  // Handshake decision.
  ////////////////////////////////////////
  // Stall beats the ready check, but only on an enabled endpoint.
  always_comb begin
    if (endPControlReg[`EP_SEND_STALL_BIT] && endPControlReg[`EP_ENABLE_BIT]) begin
      decision = RESP_STALL;
    end else if (!(endPControlReg[`EP_ENABLE_BIT] && endPControlReg[`EP_READY_BIT])) begin
      decision = RESP_NAK;
    end else begin
      decision = RESP_ACK;
    end
  end

  ////////////////////////////////////////
  // Sequencer.
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      busy <= 1'b0;
      currEndP <= '0;
      respValid <= 1'b0;
      endPMuxErrorsWEn <= 1'b0;
      clrEPRdy <= 1'b0;
    end else begin
      respValid <= 1'b0;
      endPMuxErrorsWEn <= 1'b0;
      clrEPRdy <= 1'b0;
      case (state)
        IDLE: begin
          // Busy drops one cycle after release so the ready clear lands first.
          busy <= transDone;
          if (transDone) begin
            currEndP <= tokenEndP;
            state <= LOOKUP;
          end
        end
        LOOKUP: state <= DECIDE;
        DECIDE: begin
          respValid <= 1'b1;
          endPMuxErrorsWEn <= 1'b1;
          clrEPRdy <= (decision != RESP_NAK);
          state <= RELEASE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      capTransType <= transType;
      capCrcError <= crcError;
      capBitStuffError <= bitStuffError;
      capRxOverflow <= rxOverflow;
      capRxTimeOut <= rxTimeOut;
      capAckRxed <= ackRxed;
      capDataSequence <= dataSequence;
    end
    if (state == DECIDE) begin
      respPid <= decision;
      NAKSent <= (decision == RESP_NAK);
      stallSent <= (decision == RESP_STALL);
    end
  end

  // The packet layer waits for busy to fall.
  assert property (@(posedge clk) disable iff (rst) transDone |-> !busy)
    else $error("transDone raised while busy");

endmodule

// ==== rtl/usbSlaveEndp.sv ====
module usbSlaveEndp (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    transDone,
  input  logic [3:0]              tokenEndP,
  input  usbSlavePkg::transType_t transType,
  input  logic                    crcError,
  input  logic                    bitStuffError,
  input  logic                    rxOverflow,
  input  logic                    rxTimeOut,
  input  logic                    ackRxed,
  input  logic                    dataSequence,
  output logic                    busy,
  output logic                    respValid,
  output usbSlavePkg::respPid_t   respPid,
  input  logic [4:0]              regAddr,
  input  logic [7:0]              regWrData,
  input  logic                    regWe,
  output logic [7:0]              regRdData
);

  import usbSlavePkg::*;

  transType_t capTransType;
  logic [3:0] currEndP;
  logic [4:0] endPControlReg;
  logic NAKSent;
  logic stallSent;
  logic endPMuxErrorsWEn;
  logic clrEPRdy;
  logic capCrcError;
  logic capBitStuffError;
  logic capRxOverflow;
  logic capRxTimeOut;
  logic capAckRxed;
  logic capDataSequence;
  logic [4:0] endP0ControlReg;
  logic [4:0] endP1ControlReg;
  logic [4:0] endP2ControlReg;
  logic [4:0] endP3ControlReg;
  logic [7:0] endP0StatusReg;
  logic [7:0] endP1StatusReg;
  logic [7:0] endP2StatusReg;
  logic [7:0] endP3StatusReg;
  logic [1:0] endP0TransTypeReg;
  logic [1:0] endP1TransTypeReg;
  logic [1:0] endP2TransTypeReg;
  logic [1:0] endP3TransTypeReg;
  logic [1:0] endP0NAKTransTypeReg;
  logic [1:0] endP1NAKTransTypeReg;
  logic [1:0] endP2NAKTransTypeReg;
  logic [1:0] endP3NAKTransTypeReg;
  logic clrEP0Rdy;
  logic clrEP1Rdy;
  logic clrEP2Rdy;
  logic clrEP3Rdy;

  slaveTransCtrl u_transCtrl (
    .clk              (clk),
    .rst              (rst),
    .transDone        (transDone),
    .tokenEndP        (tokenEndP),
    .transType        (transType),
    .crcError         (crcError),
    .bitStuffError    (bitStuffError),
    .rxOverflow       (rxOverflow),
    .rxTimeOut        (rxTimeOut),
    .ackRxed          (ackRxed),
    .dataSequence     (dataSequence),
    .endPControlReg   (endPControlReg),
    .busy             (busy),
    .respValid        (respValid),
    .respPid          (respPid),
    .currEndP         (currEndP),
    .NAKSent          (NAKSent),
    .stallSent        (stallSent),
    .endPMuxErrorsWEn (endPMuxErrorsWEn),
    .clrEPRdy         (clrEPRdy),
    .capTransType     (capTransType),
    .capCrcError      (capCrcError),
    .capBitStuffError (capBitStuffError),
    .capRxOverflow    (capRxOverflow),
    .capRxTimeOut     (capRxTimeOut),
    .capAckRxed       (capAckRxed),
    .capDataSequence  (capDataSequence)
  );

  // The captured type feeds both the normal and the NAK type record.
  endpMux u_endpMux (
    .clk                  (clk),
    .rst                  (rst),
    .currEndP             (currEndP),
    .NAKSent              (NAKSent),
    .stallSent            (stallSent),
    .CRCError             (capCrcError),
    .bitStuffError        (capBitStuffError),
    .RxOverflow           (capRxOverflow),
    .RxTimeOut            (capRxTimeOut),
    .dataSequence         (capDataSequence),
    .ACKRxed              (capAckRxed),
    .transType            (capTransType),
    .transTypeNAK         (capTransType),
    .endPMuxErrorsWEn     (endPMuxErrorsWEn),
    .clrEPRdy             (clrEPRdy),
    .endP0ControlReg      (endP0ControlReg),
    .endP1ControlReg      (endP1ControlReg),
    .endP2ControlReg      (endP2ControlReg),
    .endP3ControlReg      (endP3ControlReg),
    .endPControlReg       (endPControlReg),
    .endP0StatusReg       (endP0StatusReg),
    .endP1StatusReg       (endP1StatusReg),
    .endP2StatusReg       (endP2StatusReg),
    .endP3StatusReg       (endP3StatusReg),
    .endP0TransTypeReg    (endP0TransTypeReg),
    .endP1TransTypeReg    (endP1TransTypeReg),
    .endP2TransTypeReg    (endP2TransTypeReg),
    .endP3TransTypeReg    (endP3TransTypeReg),
    .endP0NAKTransTypeReg (endP0NAKTransTypeReg),
    .endP1NAKTransTypeReg (endP1NAKTransTypeReg),
    .endP2NAKTransTypeReg (endP2NAKTransTypeReg),
    .endP3NAKTransTypeReg (endP3NAKTransTypeReg),
    .clrEP0Rdy            (clrEP0Rdy),
    .clrEP1Rdy            (clrEP1Rdy),
    .clrEP2Rdy            (clrEP2Rdy),
    .clrEP3Rdy            (clrEP3Rdy)
  );

  endpRegFile u_regFile (
    .clk                  (clk),
    .rst                  (rst),
    .regAddr              (regAddr),
    .regWrData            (regWrData),
    .regWe                (regWe),
    .regRdData            (regRdData),
    .clrEP0Rdy            (clrEP0Rdy),
    .clrEP1Rdy            (clrEP1Rdy),
    .clrEP2Rdy            (clrEP2Rdy),
    .clrEP3Rdy            (clrEP3Rdy),
    .endP0StatusReg       (endP0StatusReg),
    .endP1StatusReg       (endP1StatusReg),
    .endP2StatusReg       (endP2StatusReg),
    .endP3StatusReg       (endP3StatusReg),
    .endP0TransTypeReg    (endP0TransTypeReg),
    .endP1TransTypeReg    (endP1TransTypeReg),
    .endP2TransTypeReg    (endP2TransTypeReg),
    .endP3TransTypeReg    (endP3TransTypeReg),
    .endP0NAKTransTypeReg (endP0NAKTransTypeReg),
    .endP1NAKTransTypeReg (endP1NAKTransTypeReg),
    .endP2NAKTransTypeReg (endP2NAKTransTypeReg),
    .endP3NAKTransTypeReg (endP3NAKTransTypeReg),
    .endP0ControlReg      (endP0ControlReg),
    .endP1ControlReg      (endP1ControlReg),
    .endP2ControlReg      (endP2ControlReg),
    .endP3ControlReg      (endP3ControlReg)
  );

endmodule

// ==== rtl/usbSlavePkg.sv ====
package usbSlavePkg;

  // Transaction type reported by the packet layer.
  typedef enum logic [1:0] {
    SETUP_TRANS    = 2'd0,
    IN_TRANS       = 2'd1,
    OUTDATA0_TRANS = 2'd2,
    OUTDATA1_TRANS = 2'd3
  } transType_t;

  // Handshake returned to the host.
  typedef enum logic [1:0] {
    RESP_ACK   = 2'd0,
    RESP_NAK   = 2'd1,
    RESP_STALL = 2'd2
  } respPid_t;

endpackage

// ==== usbSlaveEndp.f ====
+incdir+include
rtl/usbSlavePkg.sv
rtl/endpMux.sv
rtl/endpRegFile.sv
rtl/slaveTransCtrl.sv
rtl/usbSlaveEndp.sv
dv/tbUsbSlaveEndp.sv
